//--- all.f
hdl/crc_pkg.sv
hdl/pkt_frame_pkg.sv
hdl/crc32_byte_engine.sv
hdl/frame_parser.sv
hdl/packet_stats.sv
hdl/packet_rx_top.sv
verification/tb_clock_gen.sv
verification/packet_rx_checker.sv
verification/packet_rx_tb.sv

//--- hdl/crc32_byte_engine.sv
// CRC-32 byte engine
`timescale 1ns/100ps

module crc32_byte_engine (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            crc_init,
    input  logic                            crc_update,
    input  logic [7:0]                      data_in,
    output logic [crc_pkg::crc_width_c-1:0] crc_value,
    output logic [crc_pkg::crc_width_c-1:0] crc_next
);
    import crc_pkg::*;

    // one byte through the LFSR, MSB of the data first
    function automatic logic [crc_width_c-1:0] crc_byte(
        input logic [crc_width_c-1:0] crc_in,
        input logic [7:0]             data
    );
        logic [crc_width_c-1:0] crc;
        logic                   feedback;
        crc = crc_in;
        for (int i = 7; i >= 0; i--) begin
            feedback = crc[crc_width_c-1] ^ data[i];
            crc      = {crc[crc_width_c-2:0], 1'b0};
            if (feedback) begin
                crc = crc ^ crc_poly_c;
            end
        end
        return crc;
    endfunction

    // look-ahead value, also used by the parser for capture and residue
    always_comb begin
        crc_next = crc_byte(crc_value, data_in);
    end

    // running register, init wins over update
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc_value <= crc_init_c;
        end else if (crc_init) begin
            crc_value <= crc_init_c;
        end else if (crc_update) begin
            crc_value <= crc_next;
        end
    end

endmodule

//--- hdl/crc_pkg.sv
// CRC-32 definitions
package crc_pkg;

    // register and result width
    localparam int crc_width_c = 32;

    // generator polynomial, MSB first, non-reflected
    localparam logic [crc_width_c-1:0] crc_poly_c = 32'h04C11DB7;

    // seed loaded on the sync byte
    localparam logic [crc_width_c-1:0] crc_init_c = '1;

endpackage

//--- hdl/frame_parser.sv
// Packet framing parser
`timescale 1ns/100ps

module frame_parser (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  data_valid,
    input  logic [7:0]                            data_in,
    input  logic [crc_pkg::crc_width_c-1:0]       crc_next,
    output logic                                  crc_init,
    output logic                                  crc_update,
    output logic                                  packet_done,
    output logic                                  packet_good,
    output logic                                  packet_drop,
    output logic [crc_pkg::crc_width_c-1:0]       crc_result,
    output logic [pkt_frame_pkg::len_width_c-1:0] payload_len
);
    import crc_pkg::*;
    import pkt_frame_pkg::*;

    parse_state_e state;

    // shared by header and check fields
    logic [$clog2(header_len_c > check_len_c ? header_len_c : check_len_c)-1:0] byte_cnt;
    logic                   cnt_last;
    logic [len_width_c-1:0] payload_cnt;

    // crc seen at the terminator, published on done
    logic [crc_width_c-1:0] crc_capt;

    always_comb begin
        if (state == st_check) begin
            cnt_last = (int'(byte_cnt) == check_len_c - 1);
        end else begin
            cnt_last = (int'(byte_cnt) == header_len_c - 1);
        end
    end

    // engine controls
    assign crc_init   = data_valid && (state == st_idle) && (data_in == sync_byte_c);
    assign crc_update = data_valid && (state != st_idle);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= st_idle;
            byte_cnt    <= '0;
            payload_cnt <= '0;
            packet_done <= 1'b0;
            packet_good <= 1'b0;
            packet_drop <= 1'b0;
            crc_result  <= '0;
            payload_len <= '0;
        end else begin
            // pulses by default
            packet_done <= 1'b0;
            packet_good <= 1'b0;
            packet_drop <= 1'b0;
            if (data_valid) begin
                case (state)
                    st_idle: begin
                        if (data_in == sync_byte_c) begin
                            state       <= st_header;
                            byte_cnt    <= '0;
                            payload_cnt <= '0;
                        end
                    end
                    st_header: begin
                        if (cnt_last) begin
                            state    <= st_payload;
                            byte_cnt <= '0;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                    st_payload: begin
                        if (data_in == end_byte_c) begin
                            state <= st_check;
                        end else if (int'(payload_cnt) == max_payload_c) begin
                            // one byte too many, abort
                            packet_drop <= 1'b1;
                            state       <= st_idle;
                        end else begin
                            payload_cnt <= payload_cnt + 1'b1;
                        end
                    end
                    st_check: begin
                        if (cnt_last) begin
                            // zero residue after the check bytes means good
                            packet_done <= 1'b1;
                            packet_good <= (crc_next == '0);
                            crc_result  <= crc_capt;
                            payload_len <= payload_cnt;
                            byte_cnt    <= '0;
                            state       <= st_idle;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                    default: begin
                        state <= st_idle;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_valid && (state == st_payload) && (data_in == end_byte_c)) begin
            crc_capt <= crc_next;
        end
    end

endmodule

//--- hdl/packet_rx_top.sv
// Packet receiver top level
`timescale 1ns/100ps

module packet_rx_top (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   data_valid,
    input  logic [7:0]                             data_in,
    output logic                                   packet_done,
    output logic                                   packet_good,
    output logic                                   packet_drop,
    output logic [crc_pkg::crc_width_c-1:0]        crc_result,
    output logic [pkt_frame_pkg::len_width_c-1:0]  payload_len,
    output logic [pkt_frame_pkg::stat_width_c-1:0] good_count,
    output logic [pkt_frame_pkg::stat_width_c-1:0] bad_count,
    output logic [pkt_frame_pkg::stat_width_c-1:0] drop_count
);
    import crc_pkg::*;

    // parser to engine
    logic                   crc_init;
    logic                   crc_update;
    logic [crc_width_c-1:0] crc_next;

    frame_parser u_frame_parser (
        .clk         (clk),
        .rst_n       (rst_n),
        .data_valid  (data_valid),
        .data_in     (data_in),
        .crc_next    (crc_next),
        .crc_init    (crc_init),
        .crc_update  (crc_update),
        .packet_done (packet_done),
        .packet_good (packet_good),
        .packet_drop (packet_drop),
        .crc_result  (crc_result),
        .payload_len (payload_len)
    );

    // register value is only needed inside the engine
    crc32_byte_engine u_crc32_byte_engine (
        .clk        (clk),
        .rst_n      (rst_n),
        .crc_init   (crc_init),
        .crc_update (crc_update),
        .data_in    (data_in),
        .crc_value  (),
        .crc_next   (crc_next)
    );

    packet_stats u_packet_stats (
        .clk         (clk),
        .rst_n       (rst_n),
        .packet_done (packet_done),
        .packet_good (packet_good),
        .packet_drop (packet_drop),
        .good_count  (good_count),
        .bad_count   (bad_count),
        .drop_count  (drop_count)
    );

endmodule

//--- hdl/packet_stats.sv
// Packet statistics counters
`timescale 1ns/100ps

module packet_stats (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   packet_done,
    input  logic                                   packet_good,
    input  logic                                   packet_drop,
    output logic [pkt_frame_pkg::stat_width_c-1:0] good_count,
    output logic [pkt_frame_pkg::stat_width_c-1:0] bad_count,
    output logic [pkt_frame_pkg::stat_width_c-1:0] drop_count
);
    import pkt_frame_pkg::*;

    // sticks at all ones
    function automatic logic [stat_width_c-1:0] sat_inc(
        input logic [stat_width_c-1:0] cnt
    );
        if (&cnt) begin
            return cnt;
        end
        return cnt + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            good_count <= '0;
            bad_count  <= '0;
            drop_count <= '0;
        end else begin
            if (packet_done && packet_good) begin
                good_count <= sat_inc(good_count);
            end
            // done without good is a crc failure
            if (packet_done && !packet_good) begin
                bad_count <= sat_inc(bad_count);
            end
            if (packet_drop) begin
                drop_count <= sat_inc(drop_count);
            end
        end
    end

endmodule

//--- hdl/pkt_frame_pkg.sv
// Packet framing definitions
package pkt_frame_pkg;

    // framing bytes
    localparam logic [7:0] sync_byte_c = 8'h55;
    localparam logic [7:0] end_byte_c  = 8'hAA;

    // fixed field lengths in bytes
    localparam int header_len_c = 4;
    localparam int check_len_c  = 4;

    // longest payload accepted before abort
    localparam int max_payload_c = 64;

    // must hold 0 .. max_payload_c
    localparam int len_width_c = 7;

    // statistics counter width
    localparam int stat_width_c = 16;

    // parser states
    typedef enum logic [1:0] {
        st_idle    = 2'b00,
        st_header  = 2'b01,
        st_payload = 2'b10,
        st_check   = 2'b11
    } parse_state_e;

endpackage

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the packet receiver testbench
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module packet_rx_tb -o packet_rx_sim

# raised error limit lets the run reach its summary after an assertion failure
./obj_dir/packet_rx_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "No errors" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

//--- verification/packet_rx_checker.sv
// Packet receiver output assertions
`timescale 1ns/100ps

module packet_rx_checker (
    input logic                                   clk,
    input logic                                   rst_n,
    input logic                                   packet_done,
    input logic                                   packet_good,
    input logic                                   packet_drop,
    input logic [crc_pkg::crc_width_c-1:0]        crc_result,
    input logic [pkt_frame_pkg::len_width_c-1:0]  payload_len,
    input logic [pkt_frame_pkg::stat_width_c-1:0] good_count,
    input logic [pkt_frame_pkg::stat_width_c-1:0] bad_count,
    input logic [pkt_frame_pkg::stat_width_c-1:0] drop_count
);

    int assert_fail_count = 0;

    a_done_drop_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(packet_done && packet_drop))
    else begin
        $error("packet_done and packet_drop high in the same cycle");
        assert_fail_count++;
    end

    // good is only meaningful with done
    a_good_needs_done: assert property (@(posedge clk) disable iff (!rst_n)
        packet_good |-> packet_done)
    else begin
        $error("packet_good high without packet_done");
        assert_fail_count++;
    end

    a_done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        packet_done |=> !packet_done)
    else begin
        $error("packet_done longer than one cycle");
        assert_fail_count++;
    end

    a_reset_values: assert property (@(posedge clk)
        $rose(rst_n) |-> (!packet_done && !packet_good && !packet_drop &&
            crc_result == '0 && payload_len == '0 &&
            good_count == '0 && bad_count == '0 && drop_count == '0))
    else begin
        $error("outputs not at their reset values after reset");
        assert_fail_count++;
    end

endmodule

bind packet_rx_top packet_rx_checker u_packet_rx_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .packet_done (packet_done),
    .packet_good (packet_good),
    .packet_drop (packet_drop),
    .crc_result  (crc_result),
    .payload_len (payload_len),
    .good_count  (good_count),
    .bad_count   (bad_count),
    .drop_count  (drop_count)
);

//--- verification/packet_rx_tb.sv
// Packet receiver testbench
`timescale 1ns/100ps

module packet_rx_tb;
    import crc_pkg::*;
    import pkt_frame_pkg::*;

    localparam int clk_period_c = 40;
    localparam int num_rows_c   = 8;
    localparam int oversize_c   = 70;
    localparam int stray_c      = 2;
    localparam int pulse_wait_c = 12;

    typedef enum logic [1:0] {exp_good, exp_bad, exp_drop} outcome_e;

    typedef struct packed {
        logic [7:0] len;
        logic       corrupt;
        logic       gap;
        logic       oversize;
        outcome_e   outcome;
    } row_t;

    typedef logic [7:0] byte_q_t [$];

    // payload length, corrupt, gap, oversize, expected outcome
    row_t test_table [num_rows_c] = '{
        '{8'd0,  1'b0, 1'b0, 1'b0, exp_good},
        '{8'd1,  1'b0, 1'b0, 1'b0, exp_good},
        '{8'd5,  1'b1, 1'b0, 1'b0, exp_bad},
        '{8'd16, 1'b0, 1'b1, 1'b0, exp_good},
        '{8'd0,  1'b0, 1'b0, 1'b1, exp_drop},
        '{8'd64, 1'b0, 1'b0, 1'b0, exp_good},
        '{8'd23, 1'b1, 1'b1, 1'b0, exp_bad},
        '{8'd40, 1'b0, 1'b1, 1'b0, exp_good}
    };

    logic                    clk;
    logic                    rst_n;
    logic                    data_valid;
    logic [7:0]              data_in;
    logic                    packet_done;
    logic                    packet_good;
    logic                    packet_drop;
    logic [crc_width_c-1:0]  crc_result;
    logic [len_width_c-1:0]  payload_len;
    logic [stat_width_c-1:0] good_count;
    logic [stat_width_c-1:0] bad_count;
    logic [stat_width_c-1:0] drop_count;

    int                      err_cnt = 0;
    int                      done_seen = 0;
    int                      drop_seen = 0;
    logic                    seen_good;
    logic [crc_width_c-1:0]  seen_crc;
    logic [len_width_c-1:0]  seen_len;

    tb_clock_gen #(.period_ns(clk_period_c), .reset_cycles(2)) u_tb_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    packet_rx_top u_packet_rx_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .data_valid  (data_valid),
        .data_in     (data_in),
        .packet_done (packet_done),
        .packet_good (packet_good),
        .packet_drop (packet_drop),
        .crc_result  (crc_result),
        .payload_len (payload_len),
        .good_count  (good_count),
        .bad_count   (bad_count),
        .drop_count  (drop_count)
    );

    // pulses are sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (packet_done) begin
            done_seen++;
            seen_good = packet_good;
            seen_crc  = crc_result;
            seen_len  = payload_len;
        end
        if (packet_drop) begin
            drop_seen++;
        end
    end

    // MSB-first CRC, byte xored into the top of the register
    function automatic logic [crc_width_c-1:0] ref_crc(input byte_q_t msg);
        logic [crc_width_c-1:0] crc;
        crc = crc_init_c;
        foreach (msg[i]) begin
            crc = crc ^ {msg[i], {(crc_width_c - 8){1'b0}}};
            repeat (8) begin
                if (crc[crc_width_c-1]) begin
                    crc = (crc << 1) ^ crc_poly_c;
                end else begin
                    crc = crc << 1;
                end
            end
        end
        return crc;
    endfunction

    // never sync or terminator, so trailing oversize bytes leave the parser idle
    function automatic logic [7:0] rand_data();
        logic [7:0] b;
        b = 8'($urandom);
        if (b == end_byte_c) begin
            b = 8'hAB;
        end else if (b == sync_byte_c) begin
            b = 8'h56;
        end
        return b;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic send_byte(input logic [7:0] b, input logic gap);
        int idle;
        @(posedge clk);
        data_valid <= 1'b1;
        data_in    <= b;
        if (gap) begin
            idle = int'($urandom_range(2, 0));
            repeat (idle) begin
                @(posedge clk);
                data_valid <= 1'b0;
            end
        end
    endtask

    task automatic run_row(input int idx);
        row_t                   r;
        byte_q_t                msg;
        logic [crc_width_c-1:0] exp_crc;
        logic [7:0]             chk [check_len_c];
        int                     n_payload;
        int                     flip_idx;
        int                     flip_bit;
        int                     start_done;
        int                     start_drop;
        int                     waited;
        int                     errs_before;
        r = test_table[idx];
        errs_before = err_cnt;
        msg = {};
        for (int i = 0; i < header_len_c; i++) begin
            msg.push_back(8'($urandom));
        end
        n_payload = r.oversize ? oversize_c : int'(r.len);
        for (int i = 0; i < n_payload; i++) begin
            msg.push_back(rand_data());
        end
        if (!r.oversize) begin
            msg.push_back(end_byte_c);
        end
        exp_crc = ref_crc(msg);
        for (int i = 0; i < check_len_c; i++) begin
            chk[i] = exp_crc[8*(check_len_c-1-i) +: 8];
        end
        if (r.corrupt) begin
            flip_idx = int'($urandom_range(check_len_c - 1, 0));
            flip_bit = int'($urandom_range(7, 0));
            chk[flip_idx] = chk[flip_idx] ^ 8'(1 << flip_bit);
        end
        start_done = done_seen;
        start_drop = drop_seen;
        // stray bytes ahead of the sync byte
        if (r.gap) begin
            repeat (stray_c) send_byte(rand_data(), 1'b1);
        end
        send_byte(sync_byte_c, r.gap);
        foreach (msg[i]) begin
            send_byte(msg[i], r.gap);
        end
        if (!r.oversize) begin
            foreach (chk[i]) begin
                send_byte(chk[i], r.gap);
            end
        end
        @(posedge clk);
        data_valid <= 1'b0;
        waited = 0;
        while (done_seen == start_done && drop_seen == start_drop &&
               waited < pulse_wait_c) begin
            @(posedge clk);
            waited++;
        end
        if (waited == pulse_wait_c) begin
            $display("test %0d: no done or drop pulse within %0d cycles", idx, pulse_wait_c);
            err_cnt++;
        end else begin
            // a second pulse would show up here
            repeat (2) @(posedge clk);
            check_value("packet_done count", done_seen - start_done, r.outcome != exp_drop);
            check_value("packet_drop count", drop_seen - start_drop, r.outcome == exp_drop);
            if (r.outcome != exp_drop) begin
                check_value("packet_good", 32'(seen_good), 32'(r.outcome == exp_good));
                check_value("crc_result", seen_crc, exp_crc);
                check_value("payload_len", 32'(seen_len), 32'(r.len));
            end
        end
        if (err_cnt == errs_before) begin
            $display("test %0d: payload %0d bytes, passed", idx, n_payload);
        end else begin
            $display("test %0d: payload %0d bytes, failed", idx, n_payload);
        end
    endtask

    initial begin
        int good_rows;
        int bad_rows;
        int drop_rows;
        int assert_fails;
        data_valid = 1'b0;
        data_in    = 8'h00;
        good_rows  = 0;
        bad_rows   = 0;
        drop_rows  = 0;
        void'($urandom(76));
        wait (rst_n === 1'b1);
        repeat (2) @(posedge clk);
        for (int i = 0; i < num_rows_c; i++) begin
            run_row(i);
            repeat (3) @(posedge clk);
            case (test_table[i].outcome)
                exp_good: good_rows++;
                exp_bad:  bad_rows++;
                default:  drop_rows++;
            endcase
        end
        check_value("good_count", 32'(good_count), good_rows);
        check_value("bad_count", 32'(bad_count), bad_rows);
        check_value("drop_count", 32'(drop_count), drop_rows);
        assert_fails = u_packet_rx_top.u_packet_rx_checker.assert_fail_count;
        $display("tests %0d, check errors %0d, assertion failures %0d",
                 num_rows_c, err_cnt, assert_fails);
        if (err_cnt == 0 && assert_fails == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // limit from the byte count of the whole table
    initial begin
        longint limit_cycles;
        limit_cycles = 0;
        for (int i = 0; i < num_rows_c; i++) begin
            limit_cycles += 1 + header_len_c + (test_table[i].gap ? stray_c : 0);
            if (test_table[i].oversize) begin
                limit_cycles += oversize_c;
            end else begin
                limit_cycles += test_table[i].len + 1 + check_len_c;
            end
        end
        limit_cycles = limit_cycles * 3 + 200;
        #(limit_cycles * clk_period_c);
        $display("watchdog: run did not finish within %0d cycles", limit_cycles);
        $display("Errors found");
        $finish;
    end

endmodule

//--- verification/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2);
            clk = ~clk;
        end
    end

    // released on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule
